// File: source/isa_pkg.sv
package isa_pkg;

    localparam int data_width     = 32;  // Data, address and instruction width
    localparam int reg_index_bits = 4;
    localparam int imm_bits       = 16;
    localparam int op1_bits       = 6;
    localparam int op2_bits       = 8;

    typedef logic [data_width-1:0]     word_t;
    typedef logic [reg_index_bits-1:0] reg_index_t;
    typedef logic [op1_bits-1:0]       op1_t;
    typedef logic [op2_bits-1:0]       op2_t;
    typedef logic [1:0]                wb_src_t;

    localparam word_t inst_size = 32'd4;   // PC step in bytes
    localparam word_t start_pc  = 32'h0000_0100;

    // Low bit of each instruction field
    localparam int op1_lsb = 26;
    localparam int op2_lsb = 18;
    localparam int imm_lsb = 8;
    localparam int rd_lsb  = 8;
    localparam int rs_lsb  = 4;
    localparam int rt_lsb  = 0;

    localparam op1_t op1_alur = 6'b000000;
    localparam op1_t op1_lw   = 6'b010010;
    localparam op1_t op1_sw   = 6'b011010;
    localparam op1_t op1_addi = 6'b100000;
    localparam op1_t op1_andi = 6'b100100;
    localparam op1_t op1_ori  = 6'b100101;
    localparam op1_t op1_xori = 6'b100110;

    localparam op2_t op2_eq   = 8'b00001000;
    localparam op2_t op2_lt   = 8'b00001001;
    localparam op2_t op2_le   = 8'b00001010;
    localparam op2_t op2_ne   = 8'b00001011;
    localparam op2_t op2_add  = 8'b00100000;
    localparam op2_t op2_and  = 8'b00100100;
    localparam op2_t op2_or   = 8'b00100101;
    localparam op2_t op2_xor  = 8'b00100110;
    localparam op2_t op2_sub  = 8'b00101000;
    localparam op2_t op2_nand = 8'b00101100;
    localparam op2_t op2_nor  = 8'b00101101;
    localparam op2_t op2_nxor = 8'b00101110;
    localparam op2_t op2_rshf = 8'b00110000;
    localparam op2_t op2_lshf = 8'b00110001;

    // Write-back source select
    localparam wb_src_t wb_mem = 2'b01;
    localparam wb_src_t wb_alu = 2'b10;

    typedef struct packed {
        op1_t       op1;
        op2_t       op2;
        word_t      rs_value;
        word_t      rt_value;
        word_t      imm;       // Sign extended
        logic       use_imm;
        logic       mem_we;
        logic       mem_re;
        logic       reg_we;
        wb_src_t    wb_src;
        reg_index_t dst;
    } id_ex_t;

    typedef struct packed {
        word_t      alu_out;
        word_t      store_data;
        logic       mem_we;
        logic       mem_re;
        logic       reg_we;
        wb_src_t    wb_src;
        reg_index_t dst;
    } ex_mem_t;

    typedef struct packed {
        logic       we;
        reg_index_t index;
        word_t      data;
    } reg_write_t;

endpackage

// File: source/soc_pkg.sv
package soc_pkg;

    localparam int imem_words       = 1024;
    localparam int imem_index_bits  = $clog2(imem_words);
    localparam int dmem_words       = 16384;
    localparam int dmem_index_bits  = $clog2(dmem_words);  // Address bits 15..2
    localparam int word_offset_bits = 2;                   // Byte offset inside a word

    // Memory-mapped I/O
    localparam isa_pkg::word_t addr_hex  = 32'hFFFF_F000;
    localparam isa_pkg::word_t addr_ledr = 32'hFFFF_F020;
    localparam isa_pkg::word_t addr_key  = 32'hFFFF_F080;

    localparam int hex_bits  = 24;
    localparam int ledr_bits = 10;
    localparam int key_bits  = 4;

    localparam logic [hex_bits-1:0] hex_reset = 24'hFEDEAD;

    typedef struct packed {
        logic                       we;
        logic [imem_index_bits-1:0] addr;  // Word address
        isa_pkg::word_t             data;
    } prog_write_t;

    typedef struct packed {
        logic [hex_bits-1:0]  hex;
        logic [ledr_bits-1:0] ledr;
    } board_out_t;

endpackage

// File: source/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  soc_pkg::prog_write_t prog,
    input  logic                 stall,
    output isa_pkg::word_t       inst
);

    isa_pkg::word_t                      imem [soc_pkg::imem_words];
    isa_pkg::word_t                      pc;
    isa_pkg::word_t                      imem_word;
    logic [soc_pkg::imem_index_bits-1:0] pc_index;

    // Program load port
    always_ff @(posedge clk) begin
        if (prog.we) begin
            imem[prog.addr] <= prog.data;
        end
    end

    assign pc_index  = pc[soc_pkg::word_offset_bits +: soc_pkg::imem_index_bits];
    assign imem_word = imem[pc_index];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc   <= isa_pkg::start_pc;
            inst <= '0;                       // Zero word is a no-op
        end else if (!stall) begin
            pc   <= pc + isa_pkg::inst_size;
            inst <= imem_word;
        end
    end

    pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[soc_pkg::word_offset_bits-1:0] == '0);

endmodule

// File: source/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  isa_pkg::word_t      inst,
    output isa_pkg::reg_index_t rs_index,
    output isa_pkg::reg_index_t rt_index,
    input  isa_pkg::word_t      rs_value,
    input  isa_pkg::word_t      rt_value,
    input  isa_pkg::ex_mem_t    ex_mem,
    input  isa_pkg::reg_write_t reg_write,
    output logic                stall,
    output isa_pkg::id_ex_t     id_ex
);

    isa_pkg::op1_t                op1;
    isa_pkg::op2_t                op2;
    logic [isa_pkg::imm_bits-1:0] imm;
    isa_pkg::reg_index_t          rd;
    logic                         is_nop;
    logic                         is_alur;
    logic                         is_lw;
    logic                         is_sw;
    logic                         is_imm_alu;
    logic                         rt_used;
    logic                         rs_hazard;
    logic                         rt_hazard;
    isa_pkg::id_ex_t              decoded;

    assign op1      = inst[isa_pkg::op1_lsb +: isa_pkg::op1_bits];
    assign op2      = inst[isa_pkg::op2_lsb +: isa_pkg::op2_bits];
    assign imm      = inst[isa_pkg::imm_lsb +: isa_pkg::imm_bits];
    assign rd       = inst[isa_pkg::rd_lsb +: isa_pkg::reg_index_bits];
    assign rs_index = inst[isa_pkg::rs_lsb +: isa_pkg::reg_index_bits];
    assign rt_index = inst[isa_pkg::rt_lsb +: isa_pkg::reg_index_bits];

    // All-zero word would otherwise decode as an ALU op
    assign is_nop     = (inst == '0);
    assign is_alur    = !is_nop && (op1 == isa_pkg::op1_alur);
    assign is_lw      = (op1 == isa_pkg::op1_lw);
    assign is_sw      = (op1 == isa_pkg::op1_sw);
    assign is_imm_alu = (op1 == isa_pkg::op1_addi) || (op1 == isa_pkg::op1_andi) ||
                        (op1 == isa_pkg::op1_ori)  || (op1 == isa_pkg::op1_xori);

    always_comb begin
        decoded          = '0;
        decoded.op1      = op1;
        decoded.op2      = op2;
        decoded.rs_value = rs_value;
        decoded.rt_value = rt_value;
        decoded.imm      = {{(isa_pkg::data_width - isa_pkg::imm_bits){imm[isa_pkg::imm_bits-1]}},
                            imm};
        decoded.use_imm  = is_lw || is_sw || is_imm_alu;
        decoded.mem_we   = is_sw;
        decoded.mem_re   = is_lw;
        decoded.reg_we   = is_alur || is_lw || is_imm_alu;
        decoded.wb_src   = is_lw ? isa_pkg::wb_mem : isa_pkg::wb_alu;
        decoded.dst      = is_alur ? rd : rt_index;   // Immediate forms and LW write rt
    end

    // Sources compared against every write still in flight
    assign rt_used = is_alur || is_sw;

    assign rs_hazard = (rs_index != '0) && (
                       (id_ex.reg_we  && (id_ex.dst == rs_index)) ||
                       (ex_mem.reg_we && (ex_mem.dst == rs_index)) ||
                       (reg_write.we  && (reg_write.index == rs_index)));

    assign rt_hazard = (rt_index != '0) && (
                       (id_ex.reg_we  && (id_ex.dst == rt_index)) ||
                       (ex_mem.reg_we && (ex_mem.dst == rt_index)) ||
                       (reg_write.we  && (reg_write.index == rt_index)));

    assign stall = rs_hazard || (rt_used && rt_hazard);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex <= stall ? '0 : decoded;    // Bubble while waiting
        end
    end

    bubble_is_quiet: assert property (@(posedge clk) disable iff (reset)
        stall |=> !id_ex.reg_we && !id_ex.mem_we);

endmodule

// File: source/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  isa_pkg::reg_index_t rs_index,
    input  isa_pkg::reg_index_t rt_index,
    output isa_pkg::word_t      rs_value,
    output isa_pkg::word_t      rt_value,
    input  isa_pkg::reg_write_t reg_write
);

    localparam int reg_count = 2 ** isa_pkg::reg_index_bits;

    isa_pkg::word_t regs [reg_count];

    assign rs_value = regs[rs_index];
    assign rt_value = regs[rt_index];

    // Falling edge write, so decode sees the value in the same cycle
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.we) begin
            regs[reg_write.index] <= reg_write.data;
        end
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic             clk,
    input  logic             reset,
    input  isa_pkg::id_ex_t  id_ex,
    output isa_pkg::ex_mem_t ex_mem
);

    isa_pkg::word_t operand_a;
    isa_pkg::word_t operand_b;
    isa_pkg::word_t alu_out;

    assign operand_a = id_ex.rs_value;
    assign operand_b = id_ex.use_imm ? id_ex.imm : id_ex.rt_value;

    always_comb begin
        case (id_ex.op1)
            isa_pkg::op1_alur: begin
                case (id_ex.op2)
                    isa_pkg::op2_eq:   alu_out = isa_pkg::word_t'(operand_a == operand_b);
                    isa_pkg::op2_lt:   alu_out = isa_pkg::word_t'($signed(operand_a) <
                                                                  $signed(operand_b));
                    isa_pkg::op2_le:   alu_out = isa_pkg::word_t'($signed(operand_a) <=
                                                                  $signed(operand_b));
                    isa_pkg::op2_ne:   alu_out = isa_pkg::word_t'(operand_a != operand_b);
                    isa_pkg::op2_add:  alu_out = operand_a + operand_b;
                    isa_pkg::op2_and:  alu_out = operand_a & operand_b;
                    isa_pkg::op2_or:   alu_out = operand_a | operand_b;
                    isa_pkg::op2_xor:  alu_out = operand_a ^ operand_b;
                    isa_pkg::op2_sub:  alu_out = operand_a - operand_b;
                    isa_pkg::op2_nand: alu_out = ~(operand_a & operand_b);
                    isa_pkg::op2_nor:  alu_out = ~(operand_a | operand_b);
                    isa_pkg::op2_nxor: alu_out = ~(operand_a ^ operand_b);
                    isa_pkg::op2_rshf: alu_out = $signed(operand_a) >>> operand_b; // Arithmetic
                    isa_pkg::op2_lshf: alu_out = operand_a << operand_b;
                    default:           alu_out = '0;
                endcase
            end
            isa_pkg::op1_lw,
            isa_pkg::op1_sw,
            isa_pkg::op1_addi: alu_out = operand_a + operand_b;    // Also the memory address
            isa_pkg::op1_andi: alu_out = operand_a & operand_b;
            isa_pkg::op1_ori:  alu_out = operand_a | operand_b;
            isa_pkg::op1_xori: alu_out = operand_a ^ operand_b;
            default:           alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu_out    <= alu_out;
            ex_mem.store_data <= id_ex.rt_value;
            ex_mem.mem_we     <= id_ex.mem_we;
            ex_mem.mem_re     <= id_ex.mem_re;
            ex_mem.reg_we     <= id_ex.reg_we;
            ex_mem.wb_src     <= id_ex.wb_src;
            ex_mem.dst        <= id_ex.dst;
        end
    end

    // Decode never marks one instruction as both load and store
    load_store_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ex_mem.mem_we && ex_mem.mem_re));

endmodule

// File: source/memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  isa_pkg::ex_mem_t              ex_mem,
    input  logic [soc_pkg::key_bits-1:0]  key,
    output isa_pkg::reg_write_t           reg_write
);

    isa_pkg::word_t                      dmem [soc_pkg::dmem_words];
    logic [soc_pkg::dmem_index_bits-1:0] dmem_index;
    isa_pkg::word_t                      load_data;

    assign dmem_index = ex_mem.alu_out[soc_pkg::word_offset_bits +: soc_pkg::dmem_index_bits];

    // Keys are active low on the board
    assign load_data = (ex_mem.alu_out == soc_pkg::addr_key)
                     ? {{(isa_pkg::data_width - soc_pkg::key_bits){1'b0}}, ~key}
                     : dmem[dmem_index];

    always_ff @(posedge clk) begin
        if (ex_mem.mem_we) begin
            dmem[dmem_index] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write <= '0;
        end else begin
            reg_write.we    <= ex_mem.reg_we;
            reg_write.index <= ex_mem.dst;
            reg_write.data  <= (ex_mem.wb_src == isa_pkg::wb_mem) ? load_data : ex_mem.alu_out;
        end
    end

endmodule

// File: source/io_registers.sv
`timescale 1ns/10ps

module io_registers (
    input  logic                clk,
    input  logic                reset,
    input  isa_pkg::ex_mem_t    ex_mem,
    output soc_pkg::board_out_t board
);

    logic hex_write;
    logic ledr_write;

    // Stores decoded by address in the MEM stage
    assign hex_write  = ex_mem.mem_we && (ex_mem.alu_out == soc_pkg::addr_hex);
    assign ledr_write = ex_mem.mem_we && (ex_mem.alu_out == soc_pkg::addr_ledr);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            board.hex  <= soc_pkg::hex_reset;
            board.ledr <= '0;
        end else begin
            if (hex_write) begin
                board.hex <= ex_mem.store_data[soc_pkg::hex_bits-1:0];
            end
            if (ledr_write) begin
                board.ledr <= ex_mem.store_data[soc_pkg::ledr_bits-1:0];
            end
        end
    end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
    input  logic                         clk,
    input  logic                         reset,
    input  soc_pkg::prog_write_t         prog,
    input  logic [soc_pkg::key_bits-1:0] key,
    output soc_pkg::board_out_t          board
);

    isa_pkg::word_t      inst;
    logic                stall;
    isa_pkg::reg_index_t rs_index;
    isa_pkg::reg_index_t rt_index;
    isa_pkg::word_t      rs_value;
    isa_pkg::word_t      rt_value;
    isa_pkg::id_ex_t     id_ex;
    isa_pkg::ex_mem_t    ex_mem;
    isa_pkg::reg_write_t reg_write;

    fetch_stage u_fetch (
        .clk   (clk),
        .reset (reset),
        .prog  (prog),
        .stall (stall),
        .inst  (inst)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .rs_index  (rs_index),
        .rt_index  (rt_index),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .ex_mem    (ex_mem),
        .reg_write (reg_write),
        .stall     (stall),
        .id_ex     (id_ex)
    );

    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rs_index  (rs_index),
        .rt_index  (rt_index),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .reg_write (reg_write)
    );

    execute_stage u_execute (
        .clk    (clk),
        .reset  (reset),
        .id_ex  (id_ex),
        .ex_mem (ex_mem)
    );

    memory_stage u_memory (
        .clk       (clk),
        .reset     (reset),
        .ex_mem    (ex_mem),
        .key       (key),
        .reg_write (reg_write)
    );

    io_registers u_io (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .board  (board)
    );

endmodule

// File: tests/cpu_tb_programs.svh
// Rows of up to eight instruction words, key level, expected HEX and LEDR
// Stores to HEX use imm F000 and to LEDR imm F020, both off register 0
task automatic fill_rows();
    rows[0] = '{words: {8{32'h0}}, key: 4'h0, hex: 24'hFEDEAD, ledr: 10'h000};
    rows[1] = '{words: {
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd1, 16'h1234),
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd2, 16'hFFFD),
        reg_inst(isa_pkg::op2_add, 4'd3, 4'd1, 4'd2),
        reg_inst(isa_pkg::op2_sub, 4'd4, 4'd1, 4'd2),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd3, 16'hF000),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd4, 16'hF020), 32'h0, 32'h0},
        key: 4'h0, hex: 24'h001231, ledr: 10'h237};
    rows[2] = '{words: {
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd1, 16'h70F0),
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd2, 16'h0FF0),
        reg_inst(isa_pkg::op2_nand, 4'd3, 4'd1, 4'd2),
        reg_inst(isa_pkg::op2_nxor, 4'd4, 4'd1, 4'd2),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd3, 16'hF000),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd4, 16'hF020), 32'h0, 32'h0},
        key: 4'h0, hex: 24'hFFFF0F, ledr: 10'h0FF};
    rows[3] = '{words: {                                        // Right shift by 24 brings sign bits into LEDR
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd1, 16'hFF00),
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd2, 16'h0004),
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd5, 16'h0018),
        reg_inst(isa_pkg::op2_lshf, 4'd3, 4'd1, 4'd2),
        reg_inst(isa_pkg::op2_rshf, 4'd4, 4'd1, 4'd5),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd3, 16'hF000),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd4, 16'hF020), 32'h0},
        key: 4'h0, hex: 24'hFFF000, ledr: 10'h3FF};
    rows[4] = '{words: {                                        // 3 < -5 is false when signed
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd1, 16'hFFFB),
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd2, 16'h0003),
        reg_inst(isa_pkg::op2_lt, 4'd3, 4'd2, 4'd1),
        reg_inst(isa_pkg::op2_le, 4'd4, 4'd1, 4'd2),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd3, 16'hF000),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd4, 16'hF020), 32'h0, 32'h0},
        key: 4'h0, hex: 24'h000000, ledr: 10'h001};
    rows[5] = '{words: {
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd1, 16'hEDCB),
        imm_inst(isa_pkg::op1_andi, 4'd1, 4'd2, 16'h7F0F),
        imm_inst(isa_pkg::op1_ori, 4'd2, 4'd3, 16'h8030),
        imm_inst(isa_pkg::op1_xori, 4'd1, 4'd4, 16'hFFFF),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd3, 16'hF000),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd4, 16'hF020), 32'h0, 32'h0},
        key: 4'h0, hex: 24'hFFED3B, ledr: 10'h234};
    rows[6] = '{words: {                                        // Back-to-back chain on r5
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd5, 16'h0001),
        imm_inst(isa_pkg::op1_addi, 4'd5, 4'd5, 16'h0002),
        imm_inst(isa_pkg::op1_addi, 4'd5, 4'd5, 16'h0004),
        imm_inst(isa_pkg::op1_addi, 4'd5, 4'd5, 16'h0008),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd5, 16'hF000),
        imm_inst(isa_pkg::op1_addi, 4'd5, 4'd6, 16'h0100),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd6, 16'hF020), 32'h0},
        key: 4'h0, hex: 24'h00000F, ledr: 10'h10F};
    rows[7] = '{words: {
        imm_inst(isa_pkg::op1_addi, 4'd0, 4'd1, 16'h7ABC),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd1, 16'h0040),
        imm_inst(isa_pkg::op1_lw, 4'd0, 4'd2, 16'h0040),
        imm_inst(isa_pkg::op1_lw, 4'd0, 4'd3, 16'hF080),  // KEY read
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd2, 16'hF000),
        imm_inst(isa_pkg::op1_sw, 4'd0, 4'd3, 16'hF020), 32'h0, 32'h0},
        key: 4'h5, hex: 24'h007ABC, ledr: 10'h00A};
endtask

// File: tests/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

    localparam int num_rows     = 8;
    localparam int prog_words   = 8;
    localparam int clear_words  = 64;   // Covers every PC reached in one run
    localparam int run_cycles   = 40;
    localparam int start_index  = isa_pkg::start_pc / isa_pkg::inst_size;
    localparam int cycle_limit  = num_rows * 60 + 100;

    typedef logic [soc_pkg::imem_index_bits-1:0] imem_addr_t;

    typedef struct packed {
        isa_pkg::word_t [0:prog_words-1] words;
        logic [soc_pkg::key_bits-1:0]    key;
        logic [soc_pkg::hex_bits-1:0]    hex;
        logic [soc_pkg::ledr_bits-1:0]   ledr;
    } row_t;

    logic                         clk;
    logic                         reset;
    soc_pkg::prog_write_t         prog;
    logic [soc_pkg::key_bits-1:0] key;
    soc_pkg::board_out_t          board;

    row_t rows [num_rows];
    int   errors;
    int   checks;
    int   cycles;

    cpu_top DUT (
        .clk   (clk),
        .reset (reset),
        .prog  (prog),
        .key   (key),
        .board (board)
    );

    // Immediate, load and store format
    function automatic isa_pkg::word_t imm_inst(isa_pkg::op1_t op1, isa_pkg::reg_index_t rs,
                                                isa_pkg::reg_index_t rt, logic [15:0] imm);
        return {op1, 2'b00, imm, rs, rt};
    endfunction

    function automatic isa_pkg::word_t reg_inst(isa_pkg::op2_t op2, isa_pkg::reg_index_t rd,
                                                isa_pkg::reg_index_t rs, isa_pkg::reg_index_t rt);
        return {6'b000000, op2, 6'b000000, rd, rs, rt};
    endfunction

    `include "cpu_tb_programs.svh"

    task automatic check_hex(string name, logic [soc_pkg::hex_bits-1:0] got,
                             logic [soc_pkg::hex_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %06h, expected %06h", name, got, exp);
        end
    endtask

    task automatic check_ledr(string name, logic [soc_pkg::ledr_bits-1:0] got,
                              logic [soc_pkg::ledr_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %03h, expected %03h", name, got, exp);
        end
    endtask

    task automatic check_board(string name, soc_pkg::board_out_t got,
                               soc_pkg::board_out_t exp);
        check_hex({name, ".hex"}, got.hex, exp.hex);
        check_ledr({name, ".ledr"}, got.ledr, exp.ledr);
    endtask

    // One word per cycle, captured at the next rising edge
    task automatic write_word(int index, isa_pkg::word_t data);
        @(posedge clk);
        #1;
        prog.we   = 1'b1;
        prog.addr = imem_addr_t'(start_index + index);
        prog.data = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        #1;
        prog = '0;
    endtask

    task automatic run_row(int r);
        soc_pkg::board_out_t expected;
        expected.hex  = rows[r].hex;
        expected.ledr = rows[r].ledr;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < prog_words; i++) begin   // Also clears the previous program
            write_word(i, rows[r].words[i]);
        end
        end_writes();
        key   = rows[r].key;
        reset = 1'b0;
        repeat (run_cycles) @(posedge clk);
        #1;
        check_board($sformatf("row %0d board", r), board, expected);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        reset  = 1'b1;
        prog   = '0;
        key    = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        fill_rows();
        for (int i = 0; i < clear_words; i++) begin  // Reset stays high throughout the clear
            write_word(i, '0);
        end
        end_writes();
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        $display("Rows: %0d  checks: %0d  errors: %0d", num_rows, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tests
source/isa_pkg.sv
source/soc_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/memory_stage.sv
source/io_registers.sv
source/cpu_top.sv
tests/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f verilog.f --top-module cpu_tb \
    -Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
exit 0
